// File: list.f
verilog/distrib_pkg.sv
verilog/nth_slot_select.sv
verilog/mem_port_fill.sv
verilog/exec_port_fill.sv
verilog/port_rotator.sv
verilog/distrib_top.sv
testbench/distrib_assert.sv
testbench/tb_distrib.sv

// File: Makefile
# Verilator build and run for the slot-to-port distributor.

SIM = obj_dir/sim_distrib

all: run

compile:
	verilator --binary --timing --assert --top-module tb_distrib -f list.f \
		-Mdir obj_dir -o sim_distrib

run: compile
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: testbench/tb_distrib.sv
// Testbench for the slot-to-port distributor.
// Directed bundles and LFSR bundles with random stall are compared
// against a reference model of the fill and rotation rules.

`default_nettype none

module tb_distrib;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic rst;
  logic stall;
  distrib_pkg::slot_mask_t load;
  distrib_pkg::slot_mask_t store;
  distrib_pkg::slot_mask_t alu;
  distrib_pkg::slot_mask_t shift;
  distrib_pkg::port_pos_t  pos0;
  distrib_pkg::port_pos_t  pos1;
  distrib_pkg::port_pos_t  pos2;
  distrib_pkg::port_pos_t  pos3;
  distrib_pkg::port_pos_t  pos4;
  distrib_pkg::port_pos_t  pos5;
  distrib_pkg::port_pos_t  pos6;
  distrib_pkg::port_pos_t  pos7;
  distrib_pkg::port_pos_t  pos8;
  distrib_pkg::lane_flags_t sto;
  distrib_pkg::lane_flags_t shf;

  distrib_pkg::port_pos_t   exp_pos [9];
  distrib_pkg::lane_flags_t exp_sto;
  distrib_pkg::lane_flags_t exp_shf;
  int          mem_fill;
  int          sh_fill;
  int          mem_r = 0;  // Model offsets of the two rotated groups.
  int          sh_r = 0;
  int          errors = 0;
  int          timeouts = 0;
  int          checks = 0;
  int          edge_cnt = 0;
  time         edge_time = 0;
  logic [31:0] lfsr;

  bind distrib_top distrib_assert assert_i (.*);

  distrib_top dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    edge_time = $time;
    edge_cnt  = edge_cnt + 1;
  end

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // Waits for the next rising edge and then for offset ns past it.
  task automatic wait_edge(input int offset);
    int start;
    int polls;
    start = edge_cnt;
    polls = 0;
    while (edge_cnt == start && polls < 40) begin
      #1;
      polls++;
    end
    if (edge_cnt == start) begin
      $display("Timeout at %0t: the clock stopped toggling.", $time);
      timeouts++;
      finish_run();
    end else begin
      #(edge_time + offset - $time);
    end
  endtask

  task automatic check_value(input string what, input distrib_pkg::port_pos_t got,
                             input distrib_pkg::port_pos_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic send(input distrib_pkg::slot_mask_t ld, st, al, sh, input logic stl);
    wait_edge(2);
    load  = ld;
    store = st;
    alu   = al;
    shift = sh;
    stall = stl;
    #3;
  endtask

  function automatic logic take_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // Taps 32, 22, 2, 1.
    return lfsr[0];
  endfunction

  // The k-th occupied slot counted from slot 0, or the empty value.
  function automatic distrib_pkg::port_pos_t nth_set(distrib_pkg::slot_mask_t m, int k);
    int seen;
    distrib_pkg::port_pos_t r;
    seen = 0;
    r = distrib_pkg::pos_none;
    for (int s = 0; s < distrib_pkg::n_slots; s++) begin
      if (m[s]) begin
        if (seen == k) begin
          r    = '0;
          r[s] = 1'b1;
        end
        seen = seen + 1;
      end
    end
    return r;
  endfunction

  function automatic void expected_outputs(input distrib_pkg::slot_mask_t ld, st, al, sh,
                                           input int mr, sr);
    distrib_pkg::port_pos_t mem_l [3];
    distrib_pkg::port_pos_t sh_l [3];
    int ns;
    int nh;
    ns = ($countones(st) > 3) ? 3 : $countones(st);
    nh = ($countones(sh) > 3) ? 3 : $countones(sh);
    mem_fill = 0;
    sh_fill  = 0;
    for (int i = 0; i < 3; i++) begin
      mem_l[i] = (i < ns) ? nth_set(st, i) : nth_set(ld, i - ns);
      sh_l[i]  = (i < nh) ? nth_set(sh, i) : nth_set(al, 3 + i - nh);  // ALU ops 4 to 6.
      exp_pos[3 + i] = nth_set(al, i);
      mem_fill += (mem_l[i] != distrib_pkg::pos_none) ? 1 : 0;
      sh_fill  += (sh_l[i] != distrib_pkg::pos_none) ? 1 : 0;
    end
    for (int i = 0; i < 3; i++) begin
      exp_pos[(i + mr) % 3]     = mem_l[i];
      exp_sto[(i + mr) % 3]     = (i < ns);
      exp_pos[6 + (i + sr) % 3] = sh_l[i];
      exp_shf[(i + sr) % 3]     = (i < nh);
    end
  endfunction

  always begin : compare_proc
    distrib_pkg::port_pos_t got [9];
    wait_edge(18);
    if (!rst) begin
      expected_outputs(load, store, alu, shift, mem_r, sh_r);
      got = '{pos0, pos1, pos2, pos3, pos4, pos5, pos6, pos7, pos8};
      for (int p = 0; p < 9; p++) begin
        check_value($sformatf("pos%0d", p), got[p], exp_pos[p]);
      end
      check_value("sto", distrib_pkg::port_pos_t'(sto), distrib_pkg::port_pos_t'(exp_sto));
      check_value("shf", distrib_pkg::port_pos_t'(shf), distrib_pkg::port_pos_t'(exp_shf));
    end
    if (rst) begin
      mem_r = 0;
      sh_r  = 0;
    end else if (!stall) begin
      mem_r = (mem_r + mem_fill) % 3;
      sh_r  = (sh_r + sh_fill) % 3;
    end
  end

  initial begin
    logic [2:0] code;
    distrib_pkg::slot_mask_t m_ld;
    distrib_pkg::slot_mask_t m_st;
    distrib_pkg::slot_mask_t m_al;
    distrib_pkg::slot_mask_t m_sh;
    logic stl;
    clk   = 1'b0;
    rst   = 1'b1;
    stall = 1'b0;
    load  = '0;
    store = '0;
    alu   = '0;
    shift = '0;
    lfsr  = 32'h10fa;
    repeat (3) wait_edge(2);
    rst = 1'b0;

    send(10'h028, 10'h002, '0, '0, 1'b0);  // One store, two loads.
    check_value("pos0", pos0, 10'h002);
    check_value("pos1", pos1, 10'h008);
    check_value("pos2", pos2, 10'h020);
    check_value("sto", distrib_pkg::port_pos_t'(sto), 10'h001);
    send(10'h00a, 10'h155, '0, '0, 1'b0);  // Five stores crowd out the loads.
    check_value("pos0", pos0, 10'h001);
    check_value("pos1", pos1, 10'h004);
    check_value("pos2", pos2, 10'h010);
    check_value("sto", distrib_pkg::port_pos_t'(sto), 10'h007);
    send('0, '0, 10'h07f, 10'h200, 1'b0);
    check_value("pos3", pos3, 10'h001);
    check_value("pos4", pos4, 10'h002);
    check_value("pos5", pos5, 10'h004);
    check_value("pos6", pos6, 10'h200);
    check_value("pos7", pos7, 10'h008);
    check_value("pos8", pos8, 10'h010);
    check_value("shf", distrib_pkg::port_pos_t'(shf), 10'h001);
    send(10'h003, '0, '0, '0, 1'b0);  // Two lanes filled, offset moves to 2.
    check_value("pos2", pos2, distrib_pkg::pos_none);
    send(10'h00c, '0, '0, '0, 1'b0);
    check_value("pos0", pos0, 10'h008);
    check_value("pos1", pos1, distrib_pkg::pos_none);
    check_value("pos2", pos2, 10'h004);
    for (int k = 0; k < 4; k++) begin
      send(10'h020 << k, '0, '0, '0, k < 3);  // Offset 1 holds while stalled.
      check_value("pos1", pos1, 10'h020 << k);
    end

    for (int n = 0; n < 300; n++) begin
      m_ld = '0;
      m_st = '0;
      m_al = '0;
      m_sh = '0;
      for (int s = 0; s < distrib_pkg::n_slots; s++) begin
        code = '0;
        repeat (3) code = {code[1:0], take_bit()};
        case (code)
          3'd1, 3'd6: m_ld[s] = 1'b1;
          3'd2, 3'd7: m_st[s] = 1'b1;
          3'd3, 3'd5: m_al[s] = 1'b1;
          3'd4:       m_sh[s] = 1'b1;
          default:    m_ld[s] = 1'b0;
        endcase
      end
      stl = (n % 4 == 3) ? take_bit() : 1'b0;
      send(m_ld, m_st, m_al, m_sh, stl);
    end
    wait_edge(2);
    finish_run();
  end

endmodule

`default_nettype wire

// File: testbench/distrib_assert.sv
// Output assertions for the slot-to-port distributor.
// Every port carries one slot or the empty value, and each store or
// shift flag sits on a port that carries an op.

`default_nettype none

module distrib_assert (
  input wire                           clk,
  input wire                           rst,
  input wire distrib_pkg::port_pos_t   pos0,
  input wire distrib_pkg::port_pos_t   pos1,
  input wire distrib_pkg::port_pos_t   pos2,
  input wire distrib_pkg::port_pos_t   pos3,
  input wire distrib_pkg::port_pos_t   pos4,
  input wire distrib_pkg::port_pos_t   pos5,
  input wire distrib_pkg::port_pos_t   pos6,
  input wire distrib_pkg::port_pos_t   pos7,
  input wire distrib_pkg::port_pos_t   pos8,
  input wire distrib_pkg::lane_flags_t sto,
  input wire distrib_pkg::lane_flags_t shf
);
  timeunit 1ns;
  timeprecision 1ps;

  distrib_pkg::port_pos_t [8:0] ports;

  assign ports = {pos8, pos7, pos6, pos5, pos4, pos3, pos2, pos1, pos0};

  for (genvar g = 0; g < 9; g++) begin : g_port
    a_pos_legal: assert property (@(posedge clk) disable iff (rst)
      $onehot(ports[g]) || ports[g] == distrib_pkg::pos_none)
      else $error("Port %0d carries neither one slot nor the empty value.", g);
  end

  for (genvar g = 0; g < 3; g++) begin : g_flag
    a_sto_used: assert property (@(posedge clk) disable iff (rst)
      sto[g] |-> ports[g] != distrib_pkg::pos_none)
      else $error("Store flag %0d is set on an empty memory port.", g);
    a_shf_used: assert property (@(posedge clk) disable iff (rst)
      shf[g] |-> ports[6 + g] != distrib_pkg::pos_none)
      else $error("Shift flag %0d is set on an empty shift-group port.", g);
  end

endmodule

`default_nettype wire

// File: verilog/distrib_top.sv
// Slot-to-port distributor top level.
// Memory ports 0 to 2 and shift ports 6 to 8 pass through their own
// rotators. ALU ports 3 to 5 come straight from the execution filler.

`default_nettype none

module distrib_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          stall,
  input  wire distrib_pkg::slot_mask_t load,
  input  wire distrib_pkg::slot_mask_t store,
  input  wire distrib_pkg::slot_mask_t alu,
  input  wire distrib_pkg::slot_mask_t shift,
  output distrib_pkg::port_pos_t       pos0,
  output distrib_pkg::port_pos_t       pos1,
  output distrib_pkg::port_pos_t       pos2,
  output distrib_pkg::port_pos_t       pos3,
  output distrib_pkg::port_pos_t       pos4,
  output distrib_pkg::port_pos_t       pos5,
  output distrib_pkg::port_pos_t       pos6,
  output distrib_pkg::port_pos_t       pos7,
  output distrib_pkg::port_pos_t       pos8,
  output distrib_pkg::lane_flags_t     sto,
  output distrib_pkg::lane_flags_t     shf
);

  distrib_pkg::port_pos_t   mem_lanes [distrib_pkg::n_lanes];
  distrib_pkg::lane_flags_t mem_flags;
  distrib_pkg::port_pos_t   mem_out [distrib_pkg::n_lanes];
  distrib_pkg::port_pos_t   fixed_lanes [distrib_pkg::n_lanes];
  distrib_pkg::port_pos_t   sh_lanes [distrib_pkg::n_lanes];
  distrib_pkg::lane_flags_t sh_flags;
  distrib_pkg::port_pos_t   sh_out [distrib_pkg::n_lanes];

  mem_port_fill mem_fill (
    .store    (store),
    .load     (load),
    .lanes    (mem_lanes),
    .is_store (mem_flags)
  );

  exec_port_fill exec_fill (
    .alu         (alu),
    .shift       (shift),
    .fixed_lanes (fixed_lanes),
    .sh_lanes    (sh_lanes),
    .is_shift    (sh_flags)
  );

  port_rotator mem_rot (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .lanes_in  (mem_lanes),
    .flags_in  (mem_flags),
    .lanes_out (mem_out),
    .flags_out (sto)
  );

  port_rotator sh_rot (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .lanes_in  (sh_lanes),
    .flags_in  (sh_flags),
    .lanes_out (sh_out),
    .flags_out (shf)
  );

  assign pos0 = mem_out[0];
  assign pos1 = mem_out[1];
  assign pos2 = mem_out[2];
  assign pos3 = fixed_lanes[0];  // The ALU ports do not rotate.
  assign pos4 = fixed_lanes[1];
  assign pos5 = fixed_lanes[2];
  assign pos6 = sh_out[0];
  assign pos7 = sh_out[1];
  assign pos8 = sh_out[2];

endmodule

`default_nettype wire

// File: verilog/port_rotator.sv
// Port group rotator.
// Moves logical lane i to physical lane (i+r) mod 3, with its flag.
// The offset r advances by the number of filled lanes unless stalled.

`default_nettype none

module port_rotator (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          stall,
  input  wire distrib_pkg::port_pos_t  lanes_in [distrib_pkg::n_lanes],
  input  wire distrib_pkg::lane_flags_t flags_in,
  output distrib_pkg::port_pos_t       lanes_out [distrib_pkg::n_lanes],
  output distrib_pkg::lane_flags_t     flags_out
);

  distrib_pkg::rot_e rot_q;
  distrib_pkg::rot_e rot_d;
  logic [1:0]        fill;
  logic [2:0]        rot_sum;

  always_comb begin
    int off;
    int src;

    case (rot_q)
      distrib_pkg::rot_1: off = 1;
      distrib_pkg::rot_2: off = 2;
      default:            off = 0;
    endcase
    for (int j = 0; j < distrib_pkg::n_lanes; j++) begin
      src          = (j + distrib_pkg::n_lanes - off) % distrib_pkg::n_lanes;
      lanes_out[j] = lanes_in[src];
      flags_out[j] = flags_in[src];
    end
  end

  // Lanes fill from lane 0 up, so counting non-empty lanes gives the fill.
  always_comb begin
    fill = 2'd0;
    for (int i = 0; i < distrib_pkg::n_lanes; i++) begin
      if (lanes_in[i] != distrib_pkg::pos_none) begin
        fill = fill + 2'd1;
      end
    end
  end

  always_comb begin
    rot_sum = {1'b0, rot_q} + {1'b0, fill};
    if (rot_sum >= 3'd3) begin
      rot_sum = rot_sum - 3'd3;
    end
    rot_d = distrib_pkg::rot_e'(rot_sum[1:0]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rot_q <= distrib_pkg::rot_0;
    end else if (!stall) begin
      rot_q <= rot_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exec_port_fill.sv
// Execution lane filler.
// The first three ALU ops go to the fixed ports 3 to 5. The shift group
// takes shifts first and then ALU ops four to six.

`default_nettype none

module exec_port_fill (
  input  wire distrib_pkg::slot_mask_t  alu,
  input  wire distrib_pkg::slot_mask_t  shift,
  output distrib_pkg::port_pos_t        fixed_lanes [distrib_pkg::n_lanes],
  output distrib_pkg::port_pos_t        sh_lanes [distrib_pkg::n_lanes],
  output distrib_pkg::lane_flags_t      is_shift
);

  distrib_pkg::slot_count_t sh_cnt;
  distrib_pkg::port_pos_t   alu_picks [2*distrib_pkg::n_lanes];
  distrib_pkg::port_pos_t   sh_picks [distrib_pkg::n_lanes];

  nth_slot_select #(.n_pick(2*distrib_pkg::n_lanes)) alu_sel (
    .mask  (alu),
    .count (),
    .picks (alu_picks)
  );

  nth_slot_select #(.n_pick(distrib_pkg::n_lanes)) sh_sel (
    .mask  (shift),
    .count (sh_cnt),
    .picks (sh_picks)
  );

  always_comb begin
    int sh_used;

    sh_used = (sh_cnt > 4'd3) ? 3 : int'(sh_cnt);
    for (int i = 0; i < distrib_pkg::n_lanes; i++) begin
      fixed_lanes[i] = alu_picks[i];
      if (i < sh_used) begin
        sh_lanes[i] = sh_picks[i];
        is_shift[i] = 1'b1;
      end else begin
        sh_lanes[i] = alu_picks[distrib_pkg::n_lanes + i - sh_used];  // ALU overflow.
        is_shift[i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_port_fill.sv
// Memory lane filler.
// Places up to three stores on the memory lanes, then fills the rest
// with loads in slot order. Extra ops are dropped.

`default_nettype none

module mem_port_fill (
  input  wire distrib_pkg::slot_mask_t  store,
  input  wire distrib_pkg::slot_mask_t  load,
  output distrib_pkg::port_pos_t        lanes [distrib_pkg::n_lanes],
  output distrib_pkg::lane_flags_t      is_store
);

  distrib_pkg::slot_count_t st_cnt;
  distrib_pkg::port_pos_t   st_picks [distrib_pkg::n_lanes];
  distrib_pkg::port_pos_t   ld_picks [distrib_pkg::n_lanes];

  nth_slot_select #(.n_pick(distrib_pkg::n_lanes)) st_sel (
    .mask  (store),
    .count (st_cnt),
    .picks (st_picks)
  );

  nth_slot_select #(.n_pick(distrib_pkg::n_lanes)) ld_sel (
    .mask  (load),
    .count (),
    .picks (ld_picks)
  );

  always_comb begin
    int st_used;

    st_used = (st_cnt > 4'd3) ? 3 : int'(st_cnt);
    for (int i = 0; i < distrib_pkg::n_lanes; i++) begin
      if (i < st_used) begin
        lanes[i]    = st_picks[i];
        is_store[i] = 1'b1;
      end else begin
        lanes[i]    = ld_picks[i - st_used];  // Loads follow the stores.
        is_store[i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/nth_slot_select.sv
// N-th set bit selector.
// Counts the set slots of a mask and returns the first n_pick of them,
// lowest slot first, as one-hot positions. Missing picks are empty.

`default_nettype none

module nth_slot_select #(
  parameter int n_pick = 3
) (
  input  wire distrib_pkg::slot_mask_t  mask,
  output distrib_pkg::slot_count_t      count,
  output distrib_pkg::port_pos_t        picks [n_pick]
);

  always_comb begin
    distrib_pkg::slot_count_t run;

    run = '0;
    for (int p = 0; p < n_pick; p++) begin
      picks[p] = distrib_pkg::pos_none;
    end

    // Running prefix count tells which pick each set slot becomes.
    for (int k = 0; k < distrib_pkg::n_slots; k++) begin
      if (mask[k]) begin
        for (int p = 0; p < n_pick; p++) begin
          if (run == distrib_pkg::slot_count_t'(p)) begin
            picks[p]    = '0;
            picks[p][k] = 1'b1;
          end
        end
        run = run + 4'd1;
      end
    end

    count = run;
  end

endmodule

`default_nettype wire

// File: verilog/distrib_pkg.sv
// Slot-to-port distributor shared definitions.
// Bundle and lane sizes, slot mask and port position types, and the
// rotation offset of a three-lane port group.

`default_nettype none

package distrib_pkg;

  localparam int n_slots = 10;  // Slots in one instruction bundle.
  localparam int n_lanes = 3;   // Lanes in each port group.

  typedef logic [n_slots-1:0] slot_mask_t;
  typedef logic [n_slots-1:0] port_pos_t;  // One-hot slot position.
  typedef logic [3:0]         slot_count_t;
  typedef logic [n_lanes-1:0] lane_flags_t;

  localparam port_pos_t pos_none = '1;  // Empty port.

  typedef enum logic [1:0] {
    rot_0,
    rot_1,
    rot_2
  } rot_e;

endpackage

`default_nettype wire
